/* board_pkg.sv */
package board_pkg;

    // Host address map. Peripheral windows are offsets from BUS_BASE
    parameter logic [15:0] BUS_BASE     = 16'h4000;
    parameter logic [15:0] GPIO_BASE    = 16'h0000;
    parameter logic [15:0] COUNTER_BASE = 16'h0010;
    parameter logic [15:0] WINDOW_SIZE  = 16'h0010;

    // Register offsets inside the GPIO window
    typedef enum logic [3:0] {
        GPIO_INPUT  = 4'd0,
        GPIO_OUTPUT = 4'd1,
        GPIO_DIR    = 4'd2
    } gpio_reg_e;

    // Register offsets inside the counter window
    typedef enum logic [3:0] {
        CNT_LO    = 4'd0,  // Low byte, reading it latches the high byte
        CNT_HI    = 4'd1,  // High byte as latched by the last CNT_LO read
        CNT_CTRL  = 4'd2,  // Bit 0 enables counting
        CNT_CLEAR = 4'd3   // Any write zeroes the count
    } counter_reg_e;

    parameter int DEFAULT_IO_WIDTH    = 8;
    parameter int DEFAULT_COUNT_WIDTH = 16;

endpackage

/* bus_if.sv */
`timescale 1ns/1ps

// Peripheral side of the host bus, one instance per register window
interface bus_if;

    logic [3:0] add;      // Offset within the window
    logic [7:0] data_wr;
    logic [7:0] data_rd;  // Combinational read data from the peripheral
    logic       rd;       // Single-cycle read strobe
    logic       wr;       // Single-cycle write strobe

    modport master (
        output add,
        output data_wr,
        output rd,
        output wr,
        input  data_rd
    );

    modport slave (
        input  add,
        input  data_wr,
        input  rd,
        input  wr,
        output data_rd
    );

endinterface

/* bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
    input  logic        bus_clk,
    input  logic        rst_n,
    input  logic [15:0] add,
    input  logic [7:0]  data_in,
    input  logic        rd,
    input  logic        wr,
    output logic [7:0]  data_out,
    bus_if.master       gpio_bus,
    bus_if.master       cnt_bus
);

    logic [15:0] add_real;
    logic [15:0] gpio_off;
    logic [15:0] cnt_off;
    logic        gpio_sel;
    logic        cnt_sel;
    logic [7:0]  rd_data;

    // Addresses below BUS_BASE wrap to large values and miss both windows
    assign add_real = add - board_pkg::BUS_BASE;
    assign gpio_off = add_real - board_pkg::GPIO_BASE;
    assign cnt_off  = add_real - board_pkg::COUNTER_BASE;

    assign gpio_sel = gpio_off < board_pkg::WINDOW_SIZE;
    assign cnt_sel  = cnt_off < board_pkg::WINDOW_SIZE;

    // Only the addressed window sees a strobe, the other gets an idle bus
    assign gpio_bus.rd      = rd & gpio_sel;
    assign gpio_bus.wr      = wr & gpio_sel;
    assign gpio_bus.add     = gpio_sel ? gpio_off[3:0] : 4'h0;
    assign gpio_bus.data_wr = gpio_sel ? data_in : 8'h00;

    assign cnt_bus.rd      = rd & cnt_sel;
    assign cnt_bus.wr      = wr & cnt_sel;
    assign cnt_bus.add     = cnt_sel ? cnt_off[3:0] : 4'h0;
    assign cnt_bus.data_wr = cnt_sel ? data_in : 8'h00;

    always_comb begin
        rd_data = 8'h00;  // Unmapped addresses read as zero
        if (gpio_sel) begin
            rd_data = gpio_bus.data_rd;
        end else if (cnt_sel) begin
            rd_data = cnt_bus.data_rd;
        end
    end

    // Read data is captured on the strobe and held until the next read
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= 8'h00;
        end else if (rd) begin
            data_out <= rd_data;
        end
    end

endmodule

/* gpio_regs.sv */
`timescale 1ns/1ps

// Up to 8 GPIO pins behind one register window
module gpio_regs #(
    parameter int IO_WIDTH = 8
) (
    input  logic                bus_clk,
    input  logic                rst_n,
    input  logic [IO_WIDTH-1:0] io_in,
    output logic [IO_WIDTH-1:0] io_out,
    output logic [IO_WIDTH-1:0] io_oe,
    bus_if.slave                bus
);

    logic [IO_WIDTH-1:0] in_meta;
    logic [IO_WIDTH-1:0] in_sync;
    logic [IO_WIDTH-1:0] out_reg;
    logic [IO_WIDTH-1:0] dir_reg;
    logic                wr_out;
    logic                wr_dir;

    // Pins such as the board button change with no relation to bus_clk
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= io_in;
            in_sync <= in_meta;
        end
    end

    assign wr_out = bus.wr && (bus.add == board_pkg::GPIO_OUTPUT);
    assign wr_dir = bus.wr && (bus.add == board_pkg::GPIO_DIR);

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_reg <= '0;
            dir_reg <= '0;  // All pins start as inputs
        end else begin
            if (wr_out) begin
                out_reg <= bus.data_wr[IO_WIDTH-1:0];
            end
            if (wr_dir) begin
                dir_reg <= bus.data_wr[IO_WIDTH-1:0];
            end
        end
    end

    // Pin-side halves of a tristate pin, the pad itself sits outside
    assign io_out = out_reg;
    assign io_oe  = dir_reg;

    always_comb begin
        case (board_pkg::gpio_reg_e'(bus.add))
            board_pkg::GPIO_INPUT:  bus.data_rd = 8'(in_sync);
            board_pkg::GPIO_OUTPUT: bus.data_rd = 8'(out_reg);
            board_pkg::GPIO_DIR:    bus.data_rd = 8'(dir_reg);
            default:                bus.data_rd = 8'h00;
        endcase
    end

endmodule

/* event_counter.sv */
`timescale 1ns/1ps

// Counts rising edges of event_in, COUNT_WIDTH between 9 and 16
module event_counter #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic bus_clk,
    input  logic rst_n,
    input  logic event_in,
    bus_if.slave bus
);

    logic [2:0]             evt_pipe;   // Two synchronizer flops, then the edge-detect flop
    logic                   evt_rise;
    logic                   enable;
    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH-9:0] hi_shadow;
    logic                   clear;
    logic                   rd_lo;

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            evt_pipe <= 3'b000;
        end else begin
            evt_pipe <= {evt_pipe[1:0], event_in};
        end
    end

    assign evt_rise = evt_pipe[1] & ~evt_pipe[2];

    assign clear = bus.wr && (bus.add == board_pkg::CNT_CLEAR);
    assign rd_lo = bus.rd && (bus.add == board_pkg::CNT_LO);

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
        end else if (bus.wr && (bus.add == board_pkg::CNT_CTRL)) begin
            enable <= bus.data_wr[0];
        end
    end

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;  // Clear takes priority over a coinciding edge
        end else if (enable && evt_rise) begin
            count <= count + 1'b1;
        end
    end

    // The high byte is frozen on the low-byte read so a 16-bit value reads coherently
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            hi_shadow <= '0;
        end else if (rd_lo) begin
            hi_shadow <= count[COUNT_WIDTH-1:8];
        end
    end

    always_comb begin
        case (board_pkg::counter_reg_e'(bus.add))
            board_pkg::CNT_LO:   bus.data_rd = count[7:0];
            board_pkg::CNT_HI:   bus.data_rd = 8'(hi_shadow);
            board_pkg::CNT_CTRL: bus.data_rd = {7'b0, enable};
            default:             bus.data_rd = 8'h00;
        endcase
    end

endmodule

/* board_top.sv */
`timescale 1ns/1ps

module board_top #(
    parameter int IO_WIDTH    = board_pkg::DEFAULT_IO_WIDTH,
    parameter int COUNT_WIDTH = board_pkg::DEFAULT_COUNT_WIDTH
) (
    input  logic                bus_clk,
    input  logic                rst_n,

    // Host bus
    input  logic [15:0]         add,
    input  logic [7:0]          data_in,
    output logic [7:0]          data_out,
    input  logic                rd,
    input  logic                wr,

    // GPIO pins, split in/out/enable in place of an inout
    input  logic [IO_WIDTH-1:0] io_in,
    output logic [IO_WIDTH-1:0] io_out,
    output logic [IO_WIDTH-1:0] io_oe,

    input  logic                event_in
);

    bus_if gpio_bus ();
    bus_if cnt_bus ();

    bus_decoder i_decoder (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .add      (add),
        .data_in  (data_in),
        .rd       (rd),
        .wr       (wr),
        .data_out (data_out),
        .gpio_bus (gpio_bus.master),
        .cnt_bus  (cnt_bus.master)
    );

    gpio_regs #(
        .IO_WIDTH (IO_WIDTH)
    ) i_gpio (
        .bus_clk (bus_clk),
        .rst_n   (rst_n),
        .io_in   (io_in),
        .io_out  (io_out),
        .io_oe   (io_oe),
        .bus     (gpio_bus.slave)
    );

    event_counter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_counter (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .event_in (event_in),
        .bus      (cnt_bus.slave)
    );

endmodule

/* board_top_assertions.sv */
`timescale 1ns/1ps

module board_top_assertions #(
    parameter int IO_WIDTH = 8
) (
    input logic                bus_clk,
    input logic                rst_n,
    input logic [15:0]         add,
    input logic [7:0]          data_in,
    input logic                rd,
    input logic                wr,
    input logic [7:0]          data_out,
    input logic [IO_WIDTH-1:0] io_out,
    input logic [IO_WIDTH-1:0] io_oe
);

    // First host address of each window
    localparam logic [15:0] GPIO_FIRST = board_pkg::BUS_BASE + board_pkg::GPIO_BASE;
    localparam logic [15:0] CNT_FIRST  = board_pkg::BUS_BASE + board_pkg::COUNTER_BASE;
    localparam logic [15:0] OUT_ADDR   = GPIO_FIRST + 16'h0001;  // GPIO_OUTPUT
    localparam logic [15:0] DIR_ADDR   = GPIO_FIRST + 16'h0002;  // GPIO_DIR

    logic        mapped;

    // One counter per property, summed for the testbench
    int unsigned n_reset = 0;
    int unsigned n_out = 0;
    int unsigned n_dir = 0;
    int unsigned n_unmapped_rd = 0;
    int unsigned n_unmapped_wr = 0;
    int unsigned n_hold = 0;
    int unsigned fail_count;

    assign fail_count = n_reset + n_out + n_dir + n_unmapped_rd + n_unmapped_wr + n_hold;

    assign mapped = ((add >= GPIO_FIRST) && (add < GPIO_FIRST + board_pkg::WINDOW_SIZE)) ||
                    ((add >= CNT_FIRST) && (add < CNT_FIRST + board_pkg::WINDOW_SIZE));

    reset_values: assert property (@(posedge bus_clk)
        $rose(rst_n) |-> (io_out == '0) && (io_oe == '0) && (data_out == 8'h00))
        else begin
            n_reset++;
            $error("Outputs are not zero after reset");
        end

    out_write: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (wr && (add == OUT_ADDR)) |=> (io_out == $past(data_in[IO_WIDTH-1:0])))
        else begin
            n_out++;
            $error("io_out does not follow the GPIO_OUTPUT write");
        end

    dir_write: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (wr && (add == DIR_ADDR)) |=> (io_oe == $past(data_in[IO_WIDTH-1:0])))
        else begin
            n_dir++;
            $error("io_oe does not follow the GPIO_DIR write");
        end

    unmapped_read: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (rd && !mapped) |=> (data_out == 8'h00))
        else begin
            n_unmapped_rd++;
            $error("Unmapped read returned nonzero data");
        end

    unmapped_write: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (wr && !mapped) |=> ($stable(io_out) && $stable(io_oe)))
        else begin
            n_unmapped_wr++;
            $error("Unmapped write changed a GPIO register");
        end

    // Read data only moves on a read strobe
    data_out_hold: assert property (@(posedge bus_clk) disable iff (!rst_n)
        !rd |=> $stable(data_out))
        else begin
            n_hold++;
            $error("data_out changed without a read");
        end

endmodule

bind board_top board_top_assertions #(
    .IO_WIDTH (IO_WIDTH)
) u_assert (
    .bus_clk  (bus_clk),
    .rst_n    (rst_n),
    .add      (add),
    .data_in  (data_in),
    .rd       (rd),
    .wr       (wr),
    .data_out (data_out),
    .io_out   (io_out),
    .io_oe    (io_oe)
);

/* tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top;

    localparam int IO_WIDTH    = board_pkg::DEFAULT_IO_WIDTH;
    localparam int COUNT_WIDTH = board_pkg::DEFAULT_COUNT_WIDTH;

    logic                bus_clk;
    logic                rst_n;
    logic [15:0]         add;
    logic [7:0]          data_in;
    logic [7:0]          data_out;
    logic                rd;
    logic                wr;
    logic [IO_WIDTH-1:0] io_in;
    logic [IO_WIDTH-1:0] io_out;
    logic [IO_WIDTH-1:0] io_oe;
    logic                event_in;

    logic [31:0] seed;
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          fails_before;
    logic [7:0]  model_out;  // Expected GPIO_OUTPUT and GPIO_DIR contents
    logic [7:0]  model_dir;

    board_top #(
        .IO_WIDTH    (IO_WIDTH),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) DUT (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .add      (add),
        .data_in  (data_in),
        .data_out (data_out),
        .rd       (rd),
        .wr       (wr),
        .io_in    (io_in),
        .io_out   (io_out),
        .io_oe    (io_oe),
        .event_in (event_in)
    );

    always #20 bus_clk = ~bus_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        seed = xorshift32(seed);
        b = seed[7:0];
    endtask

    function automatic logic [15:0] gpio_addr(input logic [3:0] off);
        return board_pkg::BUS_BASE + board_pkg::GPIO_BASE + {12'h000, off};
    endfunction

    function automatic logic [15:0] cnt_addr(input logic [3:0] off);
        return board_pkg::BUS_BASE + board_pkg::COUNTER_BASE + {12'h000, off};
    endfunction

    function automatic int total_failures();
        return errors + int'(DUT.u_assert.fail_count);
    endfunction

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge bus_clk);
        #2;
        add     = addr;
        data_in = data;
        wr      = 1'b1;
        @(posedge bus_clk);
        #2;
        wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge bus_clk);
        #2;
        add = addr;
        rd  = 1'b1;
        @(posedge bus_clk);
        #2;
        rd   = 1'b0;
        data = data_out;  // Captured at the strobe edge
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic read_count(output logic [15:0] count);
        logic [7:0] lo;
        logic [7:0] hi;
        bus_read(cnt_addr(board_pkg::CNT_LO), lo);
        bus_read(cnt_addr(board_pkg::CNT_HI), hi);
        count = {hi, lo};
    endtask

    task automatic wait_count(input logic [15:0] exp);
        logic [15:0] count;
        int          tries;
        tries = 0;
        read_count(count);
        while (count !== exp && tries < 10) begin
            read_count(count);
            tries++;
        end
        if (count !== exp) begin
            $display("ERR %0t: counter read 0x%04h, expected 0x%04h", $time, count, exp);
            $display("Timeout: the counter never reached the expected count");
            errors++;
        end
    endtask

    task automatic wait_pins(input logic [7:0] exp_out, input logic [7:0] exp_oe);
        int n;
        n = 0;
        while ((io_out !== exp_out || io_oe !== exp_oe) && n < 8) begin
            @(posedge bus_clk);
            #2;
            n++;
        end
        if (io_out !== exp_out || io_oe !== exp_oe) begin
            $display("Timeout: the GPIO pins never showed the written values");
            errors++;
        end
    endtask

    task automatic pulse_event(input int high_cycles, input int low_cycles);
        @(posedge bus_clk);
        #2;
        event_in = 1'b1;
        repeat (high_cycles) @(posedge bus_clk);
        #2;
        event_in = 1'b0;
        repeat (low_cycles) @(posedge bus_clk);
    endtask

    task automatic end_test(input string name);
        if (total_failures() == fails_before) begin
            tests_ok++;
            $display("Test %s: ok", name);
        end else begin
            tests_bad++;
            $display("Test %s: FAIL", name);
        end
        fails_before = total_failures();
    endtask

    initial begin
        logic [7:0]  b;
        logic [7:0]  got;
        logic [15:0] count;
        int          npulse;
        bus_clk      = 1'b0;
        rst_n        = 1'b0;
        add          = 16'h0000;
        data_in      = 8'h00;
        rd           = 1'b0;
        wr           = 1'b0;
        io_in        = '0;
        event_in     = 1'b0;
        seed         = 32'hab91_a67d;
        errors       = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        fails_before = 0;
        model_out    = 8'h00;
        model_dir    = 8'h00;
        repeat (2) @(posedge bus_clk);
        #2;
        rst_n = 1'b1;

        bus_read(gpio_addr(board_pkg::GPIO_OUTPUT), got);
        check_byte("GPIO_OUTPUT after reset", got, 8'h00);
        bus_read(gpio_addr(board_pkg::GPIO_DIR), got);
        check_byte("GPIO_DIR after reset", got, 8'h00);
        bus_read(cnt_addr(board_pkg::CNT_CTRL), got);
        check_byte("CNT_CTRL after reset", got, 8'h00);
        end_test("reset values");

        repeat (4) begin
            rand_byte(model_out);
            rand_byte(model_dir);
            bus_write(gpio_addr(board_pkg::GPIO_OUTPUT), model_out);
            bus_write(gpio_addr(board_pkg::GPIO_DIR), model_dir);
            wait_pins(model_out, model_dir);
            bus_read(gpio_addr(board_pkg::GPIO_OUTPUT), got);
            check_byte("GPIO_OUTPUT", got, model_out);
            bus_read(gpio_addr(board_pkg::GPIO_DIR), got);
            check_byte("GPIO_DIR", got, model_dir);
        end
        end_test("gpio write and read-back");

        repeat (4) begin
            rand_byte(b);
            @(posedge bus_clk);
            #2;
            io_in = b;
            repeat (2) @(posedge bus_clk);  // Two synchronizer flops
            bus_read(gpio_addr(board_pkg::GPIO_INPUT), got);
            check_byte("GPIO_INPUT", got, b);
        end
        end_test("gpio input");

        rand_byte(b);
        bus_write(board_pkg::BUS_BASE + 16'h0040, b);
        bus_write(16'h3fff, ~b);
        bus_write(16'h3ff1, b);  // Just below the GPIO window after the wrap
        bus_read(board_pkg::BUS_BASE + 16'h0040, got);
        check_byte("unmapped BUS_BASE+0x40", got, 8'h00);
        bus_read(16'h3fff, got);
        check_byte("unmapped 0x3fff", got, 8'h00);
        bus_read(gpio_addr(board_pkg::GPIO_OUTPUT), got);
        check_byte("GPIO_OUTPUT after unmapped writes", got, model_out);
        bus_read(gpio_addr(board_pkg::GPIO_DIR), got);
        check_byte("GPIO_DIR after unmapped writes", got, model_dir);
        end_test("unmapped addresses");

        bus_write(cnt_addr(board_pkg::CNT_CLEAR), 8'h00);
        bus_write(cnt_addr(board_pkg::CNT_CTRL), 8'h01);
        rand_byte(b);
        npulse = 3 + int'(b[2:0]);
        repeat (npulse) pulse_event(2, 2);
        wait_count(16'(npulse));
        bus_write(cnt_addr(board_pkg::CNT_CTRL), 8'h00);
        repeat (3) pulse_event(2, 2);
        read_count(count);
        if (count !== 16'(npulse)) begin
            $display("ERR %0t: disabled counter moved to 0x%04h", $time, count);
            errors++;
        end
        end_test("event counting");

        bus_write(cnt_addr(board_pkg::CNT_CLEAR), 8'h00);
        wait_count(16'h0000);
        bus_write(cnt_addr(board_pkg::CNT_CTRL), 8'h01);
        rand_byte(b);
        npulse = 256 + int'(b[3:0]);  // Past 255 so the high byte is nonzero
        repeat (npulse) pulse_event(2, 2);
        wait_count(16'(npulse));
        bus_write(cnt_addr(board_pkg::CNT_CLEAR), 8'hff);
        // CNT_HI still holds the byte latched by the last CNT_LO read
        bus_read(cnt_addr(board_pkg::CNT_HI), got);
        check_byte("CNT_HI after clear", got, 8'(npulse >> 8));
        wait_count(16'h0000);
        end_test("counter clear and high byte");

        $display("Tests: %0d ok, %0d failed, %0d check failures",
                 tests_ok, tests_bad, total_failures());
        if (tests_bad == 0 && total_failures() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(2_000_000);
        $display("Timeout: the simulation did not finish within its time limit");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim.f */
board_pkg.sv
bus_if.sv
bus_decoder.sv
gpio_regs.sv
event_counter.sv
board_top.sv
board_top_assertions.sv
tb_board_top.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_board_top

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module "$TOP" -f sim.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ "$run_status" -ne 0 ]; then
    echo "Simulation executable returned status $run_status"
    exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
    exit 0
fi

echo "Pass line not found in $LOG"
exit 1
